//--- src/board_pkg.sv
// Board constants, host status bit map and shared types.
// Fixed for one board with 4-bit colour and two fire buttons.
// Raw joystick words are active high, game inputs active low.

`default_nettype none

package board_pkg;

    localparam int COLORW = 4;
    localparam int OUTW = 8;
    localparam logic [11:0] VIDEO_WIDTH = 12'd384;
    localparam logic [11:0] VIDEO_HEIGHT = 12'd224;
    localparam int BUTTONS = 2;
    localparam bit INPUTS_ACTIVE_LOW = 1'b1;
    localparam int RST_HOLD = 32;

    // Derived constants
    localparam int RST_CW = $clog2(RST_HOLD + 1);
    localparam logic [5:0] BTN_MASK = 6'((1 << BUTTONS) - 1);
    localparam int WIDEN_REP = (OUTW + COLORW - 1) / COLORW;

    // Host status word
    localparam int ST_PAUSE = 1;
    localparam int ST_ROTCTRL = 2;
    localparam int ST_FLIP = 3;
    localparam int ST_TEST = 4;
    localparam int ST_FX = 5;
    localparam int ST_NOFM = 7;
    localparam int ST_NOPSG = 8;
    localparam int ST_ASPECT = 12;

    // Raw board word, upper bits
    localparam int BJ_COIN = 10;
    localparam int BJ_START = 11;
    localparam int BJ_SERVICE = 12;
    localparam int BJ_PAUSE = 13;

    typedef struct packed {
        logic [5:0] buttons;
        logic       up;
        logic       down;
        logic       left;
        logic       right;
    } game_joy_t;

    // Bits 15..10 are reached through the BJ_ positions
    typedef struct packed {
        logic [5:0] sys;
        game_joy_t  joy;
    } board_joy_t;

    typedef struct packed {
        logic       osd_pause;
        logic       rot_control;
        logic       flip;
        logic       test;
        logic [1:0] fxlevel;
        logic       enable_fm;
        logic       enable_psg;
    } dip_cfg_t;

    typedef struct packed {
        logic [11:0] arx;
        logic [11:0] ary;
    } aspect_t;

    typedef struct packed {
        logic [COLORW-1:0] r;
        logic [COLORW-1:0] g;
        logic [COLORW-1:0] b;
        logic              hs;
        logic              vs;
        logic              lhbl;
        logic              lvbl;
    } video_in_t;

    typedef struct packed {
        logic [OUTW-1:0] r;
        logic [OUTW-1:0] g;
        logic [OUTW-1:0] b;
        logic            hs;
        logic            vs;
        logic            de;
    } video_out_t;

endpackage

`default_nettype wire

//--- src/board_reset.sv
// Game reset stretcher. Any cause raises game_rst on the next cycle.
// game_rst stays high for RST_HOLD cycles after the last cycle with a
// cause and is low in the cycle after that. rst acts like a held cause.

`default_nettype none

module board_reset import board_pkg::*; (
    input  logic clk_sys,
    input  logic rst,
    input  logic rst_req,
    input  logic pll_locked,
    input  logic downloading,
    input  logic soft_rst,
    input  logic flip,
    output logic game_rst
);

    logic              flip_l;
    logic              cause;
    logic [RST_CW-1:0] cnt;

    // Changing the screen flip restarts the game
    assign cause = rst_req | ~pll_locked | downloading | soft_rst | (flip != flip_l);

    always_ff @(posedge clk_sys) begin
        flip_l <= flip;
        if (rst) begin
            cnt      <= RST_CW'(RST_HOLD);
            game_rst <= 1'b1;
        end else if (cause) begin
            cnt      <= RST_CW'(RST_HOLD);
            game_rst <= 1'b1;
        end else begin
            if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end
            // Last high cycle is the one where cnt reads 1
            game_rst <= cnt > RST_CW'(1);
        end
    end

    a_hold_covers_count: assert property (
        @(posedge clk_sys) disable iff (rst) (cnt != '0) |-> game_rst
    );

endmodule

`default_nettype wire

//--- src/board_dip.sv
// Host status word decode. Outputs are registered, one cycle behind status.
// Aspect field: 1 is 4:3, 2 is 16:9, anything else the native size.
// A rotated screen swaps the aspect pair.

`default_nettype none

module board_dip import board_pkg::*; (
    input  logic        clk_sys,
    input  logic        rst,
    input  logic [31:0] status,
    output dip_cfg_t    cfg,
    output aspect_t     aspect
);

    dip_cfg_t cfg_d;
    aspect_t  base;
    aspect_t  aspect_d;

    always_comb begin
        cfg_d.osd_pause   = status[ST_PAUSE];
        cfg_d.rot_control = status[ST_ROTCTRL];
        cfg_d.flip        = status[ST_FLIP];
        cfg_d.test        = status[ST_TEST];
        cfg_d.fxlevel     = status[ST_FX +: 2];
        // Status bits disable the chips, outputs enable them
        cfg_d.enable_fm   = ~status[ST_NOFM];
        cfg_d.enable_psg  = ~status[ST_NOPSG];
    end

    always_comb begin
        case (status[ST_ASPECT +: 2])
            2'd1: begin
                base.arx = 12'd4;
                base.ary = 12'd3;
            end
            2'd2: begin
                base.arx = 12'd16;
                base.ary = 12'd9;
            end
            default: begin
                base.arx = VIDEO_WIDTH;
                base.ary = VIDEO_HEIGHT;
            end
        endcase
        if (status[ST_ROTCTRL]) begin
            aspect_d.arx = base.ary;
            aspect_d.ary = base.arx;
        end else begin
            aspect_d = base;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            cfg        <= '0;
            aspect.arx <= VIDEO_WIDTH;
            aspect.ary <= VIDEO_HEIGHT;
        end else begin
            cfg    <= cfg_d;
            aspect <= aspect_d;
        end
    end

endmodule

`default_nettype wire

//--- src/board_inputs.sv
// Board joystick merge into game inputs, one register stage.
// Rotation remap applies only with rot_control; flip only acts on top of it.
// Buttons above BUTTONS read inactive. Service is taken from player 1.
// soft_rst pulses once when player 1 start and service become held together.

`default_nettype none

module board_inputs import board_pkg::*; (
    input  logic                  clk_sys,
    input  logic                  rst,
    input  board_joy_t      [3:0] board_joy,
    input  dip_cfg_t              cfg,
    output game_joy_t       [3:0] game_joy,
    output logic            [3:0] game_coin,
    output logic            [3:0] game_start,
    output logic                  game_service,
    output logic                  game_pause,
    output logic                  soft_rst
);

    logic            [3:0] pause_raw;
    logic            [3:0] pause_prev;
    logic                  pause_latch;
    logic                  pause_next;
    logic                  combo;
    logic                  combo_prev;
    game_joy_t       [3:0] joy_next;

    function automatic game_joy_t remap(
        input game_joy_t j,
        input logic      rot,
        input logic      flip
    );
        game_joy_t r;
        r = j;
        r.buttons = j.buttons & BTN_MASK;
        if (rot) begin
            // Screen turned a quarter turn clockwise
            r.up    = flip ? j.right : j.left;
            r.down  = flip ? j.left  : j.right;
            r.left  = flip ? j.up    : j.down;
            r.right = flip ? j.down  : j.up;
        end
        return r;
    endfunction

    always_comb begin
        for (int p = 0; p < 4; p++) begin
            pause_raw[p] = board_joy[p][BJ_PAUSE];
            joy_next[p]  = remap(board_joy[p].joy, cfg.rot_control, cfg.flip);
        end
        // Any player's pause press toggles
        pause_next = pause_latch ^ (|(pause_raw & ~pause_prev));
        combo      = board_joy[0][BJ_START] & board_joy[0][BJ_SERVICE];
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_joy     <= {$bits(game_joy){INPUTS_ACTIVE_LOW}};
            game_coin    <= {4{INPUTS_ACTIVE_LOW}};
            game_start   <= {4{INPUTS_ACTIVE_LOW}};
            game_service <= INPUTS_ACTIVE_LOW;
            game_pause   <= 1'b0;
            pause_latch  <= 1'b0;
            pause_prev   <= '0;
            combo_prev   <= 1'b0;
            soft_rst     <= 1'b0;
        end else begin
            for (int p = 0; p < 4; p++) begin
                game_joy[p]   <= game_joy_t'(joy_next[p] ^ {$bits(game_joy_t){INPUTS_ACTIVE_LOW}});
                game_coin[p]  <= board_joy[p][BJ_COIN] ^ INPUTS_ACTIVE_LOW;
                game_start[p] <= board_joy[p][BJ_START] ^ INPUTS_ACTIVE_LOW;
            end
            game_service <= board_joy[0][BJ_SERVICE] ^ INPUTS_ACTIVE_LOW;
            pause_prev   <= pause_raw;
            pause_latch  <= pause_next;
            game_pause   <= pause_next | cfg.osd_pause;
            combo_prev   <= combo;
            soft_rst     <= combo & ~combo_prev;
        end
    end

    a_soft_rst_single: assert property (
        @(posedge clk_sys) disable iff (rst) soft_rst |=> !soft_rst
    );

endmodule

`default_nettype wire

//--- src/board_video.sv
// Video output stage. Captures on pxl_cen and holds between enables.
// Colour is widened by bit repetition, so full scale stays full scale.
// de is high only inside both the horizontal and vertical active areas.

`default_nettype none

module board_video import board_pkg::*; (
    input  logic       clk_sys,
    input  logic       rst,
    input  logic       pxl_cen,
    input  video_in_t  vin,
    output video_out_t vout
);

    // With 4 bits this is v * 17
    function automatic logic [OUTW-1:0] widen(input logic [COLORW-1:0] c);
        logic [WIDEN_REP*COLORW-1:0] rep;
        rep = {WIDEN_REP{c}};
        return rep[WIDEN_REP*COLORW-1 -: OUTW];
    endfunction

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            vout <= '0;
        end else if (pxl_cen) begin
            vout.r  <= widen(vin.r);
            vout.g  <= widen(vin.g);
            vout.b  <= widen(vin.b);
            vout.hs <= vin.hs;
            vout.vs <= vin.vs;
            vout.de <= vin.lhbl & vin.lvbl;
        end
    end

    a_vblank_no_de: assert property (
        @(posedge clk_sys) disable iff (rst) (pxl_cen && !vin.lvbl) |=> !vout.de
    );

endmodule

`default_nettype wire

//--- src/board_top.sv
// Board wrapper top. Single clock domain, no added latency here.
// Block timing shows at the outputs unchanged.
// game_rst also covers the power-up rst stretch.

`default_nettype none

module board_top import board_pkg::*; (
    input  logic                  clk_sys,
    input  logic                  rst,
    input  logic                  rst_req,
    input  logic                  pll_locked,
    input  logic                  downloading,
    input  logic                  pxl_cen,
    input  logic           [31:0] status,
    input  board_joy_t      [3:0] board_joy,
    input  video_in_t             vin,
    output logic                  game_rst,
    output game_joy_t       [3:0] game_joy,
    output logic            [3:0] game_coin,
    output logic            [3:0] game_start,
    output logic                  game_service,
    output logic                  game_pause,
    output dip_cfg_t              cfg,
    output aspect_t               aspect,
    output video_out_t            vout
);

    logic soft_rst;

    board_dip u_dip (
        .clk_sys      ( clk_sys      ),
        .rst          ( rst          ),
        .status       ( status       ),
        .cfg          ( cfg          ),
        .aspect       ( aspect       )
    );

    board_inputs u_inputs (
        .clk_sys      ( clk_sys      ),
        .rst          ( rst          ),
        .board_joy    ( board_joy    ),
        .cfg          ( cfg          ),
        .game_joy     ( game_joy     ),
        .game_coin    ( game_coin    ),
        .game_start   ( game_start   ),
        .game_service ( game_service ),
        .game_pause   ( game_pause   ),
        .soft_rst     ( soft_rst     )
    );

    board_reset u_reset (
        .clk_sys      ( clk_sys      ),
        .rst          ( rst          ),
        .rst_req      ( rst_req      ),
        .pll_locked   ( pll_locked   ),
        .downloading  ( downloading  ),
        .soft_rst     ( soft_rst     ),
        .flip         ( cfg.flip     ),
        .game_rst     ( game_rst     )
    );

    board_video u_video (
        .clk_sys      ( clk_sys      ),
        .rst          ( rst          ),
        .pxl_cen      ( pxl_cen      ),
        .vin          ( vin          ),
        .vout         ( vout         )
    );

endmodule

`default_nettype wire

//--- sim/board_checker.sv
// Reference model of board_top and output comparison.
// The model updates on the rising edge and is compared on the falling
// edge, when DUT outputs are stable. Model flip and osd_pause come
// from the model's own decoded settings, not from the DUT.

`default_nettype none

module board_checker import board_pkg::*; (
    input  logic                  clk_sys,
    input  logic                  rst,
    input  logic                  rst_req,
    input  logic                  pll_locked,
    input  logic                  downloading,
    input  logic                  pxl_cen,
    input  logic           [31:0] status,
    input  board_joy_t      [3:0] board_joy,
    input  video_in_t             vin,
    input  logic                  game_rst,
    input  game_joy_t       [3:0] game_joy,
    input  logic            [3:0] game_coin,
    input  logic            [3:0] game_start,
    input  logic                  game_service,
    input  logic                  game_pause,
    input  dip_cfg_t              cfg,
    input  aspect_t               aspect,
    input  video_out_t            vout,
    output int                    errors,
    output int                    checks
);

    dip_cfg_t        exp_cfg;
    aspect_t         exp_aspect;
    logic [3:0][9:0] exp_joy;
    logic [3:0]      exp_coin;
    logic [3:0]      exp_start;
    logic            exp_service;
    logic            exp_pause;
    logic            exp_rst;
    video_out_t      exp_vout;
    logic            latch;
    logic [3:0]      pause_prev;
    logic            combo_prev;
    logic            soft_pulse;
    logic            prev_flip;
    int              since;
    logic            armed = 1'b0;
    int              err_count = 0;
    int              check_count = 0;
    logic [3:0][9:0] joy_next;
    logic            toggle;
    logic            cause;

    assign errors = err_count;
    assign checks = check_count;

    // Directions as {up, down, left, right}, active-low result
    function automatic logic [9:0] expected_joy(input logic [15:0] w, input logic rot,
                                                input logic flip);
        logic [3:0] dir;
        logic [5:0] btn;
        dir = w[3:0];
        if (rot) begin
            dir = flip ? {w[0], w[1], w[3], w[2]} : {w[1], w[0], w[2], w[3]};
        end
        btn = w[9:4];
        for (int k = BUTTONS; k < 6; k++) begin
            btn[k] = 1'b0;
        end
        return ~{btn, dir};
    endfunction

    function automatic aspect_t expected_aspect(input logic [31:0] s);
        aspect_t a;
        case (s[ST_ASPECT +: 2])
            2'd1: a = '{arx: 12'd4, ary: 12'd3};
            2'd2: a = '{arx: 12'd16, ary: 12'd9};
            default: a = '{arx: VIDEO_WIDTH, ary: VIDEO_HEIGHT};
        endcase
        if (s[ST_ROTCTRL]) begin
            a = '{arx: a.ary, ary: a.arx};
        end
        return a;
    endfunction

    function automatic logic [7:0] widened(input logic [3:0] v);
        return 8'(v) * 8'd17;
    endfunction

    task automatic compare_value(input string name, input logic [63:0] exp_v,
                                 input logic [63:0] act_v);
        check_count++;
        if (act_v !== exp_v) begin
            err_count++;
            $display("[FAIL] time %0t %s expected %0h actual %0h", $time, name, exp_v, act_v);
        end
    endtask

    always_comb begin
        toggle = 1'b0;
        for (int p = 0; p < 4; p++) begin
            joy_next[p] = expected_joy(board_joy[p], exp_cfg.rot_control, exp_cfg.flip);
            toggle = toggle | (board_joy[p][BJ_PAUSE] & ~pause_prev[p]);
        end
        cause = rst_req | ~pll_locked | downloading | soft_pulse | (exp_cfg.flip != prev_flip);
    end

    always @(posedge clk_sys) begin
        prev_flip <= exp_cfg.flip;
        if (rst) begin
            armed       <= 1'b1;
            exp_cfg     <= '0;
            exp_aspect  <= '{arx: VIDEO_WIDTH, ary: VIDEO_HEIGHT};
            exp_joy     <= '1;
            exp_coin    <= '1;
            exp_start   <= '1;
            exp_service <= 1'b1;
            exp_pause   <= 1'b0;
            latch       <= 1'b0;
            pause_prev  <= '0;
            combo_prev  <= 1'b0;
            soft_pulse  <= 1'b0;
            exp_vout    <= '0;
            since       <= 0;
            exp_rst     <= 1'b1;
        end else begin
            exp_cfg.osd_pause   <= status[ST_PAUSE];
            exp_cfg.rot_control <= status[ST_ROTCTRL];
            exp_cfg.flip        <= status[ST_FLIP];
            exp_cfg.test        <= status[ST_TEST];
            exp_cfg.fxlevel     <= status[ST_FX +: 2];
            exp_cfg.enable_fm   <= ~status[ST_NOFM];
            exp_cfg.enable_psg  <= ~status[ST_NOPSG];
            exp_aspect <= expected_aspect(status);
            exp_joy    <= joy_next;
            for (int p = 0; p < 4; p++) begin
                exp_coin[p]   <= ~board_joy[p][BJ_COIN];
                exp_start[p]  <= ~board_joy[p][BJ_START];
                pause_prev[p] <= board_joy[p][BJ_PAUSE];
            end
            exp_service <= ~board_joy[0][BJ_SERVICE];
            latch       <= latch ^ toggle;
            exp_pause   <= (latch ^ toggle) | exp_cfg.osd_pause;
            combo_prev  <= board_joy[0][BJ_START] & board_joy[0][BJ_SERVICE];
            soft_pulse  <= board_joy[0][BJ_START] & board_joy[0][BJ_SERVICE] & ~combo_prev;
            if (pxl_cen) begin
                exp_vout <= '{r: widened(vin.r), g: widened(vin.g), b: widened(vin.b),
                              hs: vin.hs, vs: vin.vs, de: vin.lhbl & vin.lvbl};
            end
            // Cycles since the last cause, game_rst low after RST_HOLD of them
            if (cause) begin
                since   <= 0;
                exp_rst <= 1'b1;
            end else begin
                if (since < RST_HOLD) begin
                    since <= since + 1;
                end
                exp_rst <= (since + 1) < RST_HOLD;
            end
        end
    end

    always @(negedge clk_sys) begin
        if (armed) begin
            compare_value("game_rst", 64'(exp_rst), 64'(game_rst));
            compare_value("game_joy", 64'(exp_joy), 64'(game_joy));
            compare_value("game_coin", 64'(exp_coin), 64'(game_coin));
            compare_value("game_start", 64'(exp_start), 64'(game_start));
            compare_value("game_service", 64'(exp_service), 64'(game_service));
            compare_value("game_pause", 64'(exp_pause), 64'(game_pause));
            compare_value("cfg", 64'(exp_cfg), 64'(cfg));
            compare_value("aspect", 64'(exp_aspect), 64'(aspect));
            compare_value("vout", 64'(exp_vout), 64'(vout));
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_board.sv
// Testbench for board_top with xorshift stimulus from a fixed seed.
// Busy stretches of 64 cycles alternate with quiet ones, so that
// the game reset stretch can run out. board_checker does the comparing.

`default_nettype none

module tb_board import board_pkg::*; ();

    localparam int STIM_CYCLES = 2000;
    // Stimulus plus reset and margin
    localparam int TIMEOUT = 3000;

    logic                  clk_sys = 1'b0;
    logic                  rst;
    logic                  rst_req;
    logic                  pll_locked;
    logic                  downloading;
    logic                  pxl_cen;
    logic           [31:0] status;
    board_joy_t      [3:0] board_joy;
    video_in_t             vin;
    logic                  game_rst;
    game_joy_t       [3:0] game_joy;
    logic            [3:0] game_coin;
    logic            [3:0] game_start;
    logic                  game_service;
    logic                  game_pause;
    dip_cfg_t              cfg;
    aspect_t               aspect;
    video_out_t            vout;
    logic           [31:0] rng = 32'd25;
    int                    cycles = 0;
    int                    errors;
    int                    checks;

    board_top dut (.*);

    board_checker chk (.*);

    always #2 clk_sys = ~clk_sys;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic drive_cycle(input int i);
        logic [31:0]     a;
        logic [31:0]     b;
        logic [31:0]     c;
        logic [31:0]     d;
        logic [31:0]     e;
        logic            quiet;
        board_joy_t [3:0] bj;
        rng = xorshift32(rng);
        a = rng;
        rng = xorshift32(rng);
        b = rng;
        rng = xorshift32(rng);
        c = rng;
        rng = xorshift32(rng);
        d = rng;
        rng = xorshift32(rng);
        e = rng;
        quiet = i[6];
        bj = {b, a};
        // Service kept rare, start plus service means a soft reset
        // Quiet stretches allow it only in their last 16 cycles, after game_rst fell
        bj[0][BJ_SERVICE] = e[0] && e[1] && (!quiet || (i[5:4] == 2'b11));
        board_joy   <= bj;
        vin         <= video_in_t'(c[31:16]);
        pxl_cen     <= c[8];
        rst_req     <= !quiet && (c[11:9] == 3'd0);
        pll_locked  <= quiet || (c[14:12] != 3'd0);
        downloading <= !quiet && (c[7:3] == 5'd0);
        if (!quiet && (e[4:2] == 3'd0)) begin
            status <= d;
        end
    endtask

    initial begin
        rst         <= 1'b1;
        rst_req     <= 1'b0;
        pll_locked  <= 1'b1;
        downloading <= 1'b0;
        pxl_cen     <= 1'b0;
        status      <= '0;
        board_joy   <= '0;
        vin         <= '0;
        repeat (16) @(posedge clk_sys);
        rst <= 1'b0;
        for (int i = 0; i < STIM_CYCLES; i++) begin
            drive_cycle(i);
            @(posedge clk_sys);
        end
        repeat (4) @(posedge clk_sys);
        $display("Run complete: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    always @(posedge clk_sys) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("Timeout: run did not end within %0d cycles", TIMEOUT);
            $display("Checks failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- flist.f
src/board_pkg.sv
src/board_reset.sv
src/board_dip.sv
src/board_inputs.sv
src/board_video.sv
src/board_top.sv
sim/board_checker.sv
sim/tb_board.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the board testbench with Verilator and runs it.
# The run fails if the log holds the testbench's fail line.

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert --top-module tb_board -f flist.f -o tb_board
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_board > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "Checks failed" "$LOG"; then
    exit 1
fi
exit 0
